// ==== hw/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

	localparam int ADDR_W  = 32;
	localparam int DATA_W  = 32;
	localparam int SEL_W   = DATA_W / 8;     // One select bit per byte lane
	localparam int STALL_W = 6;

	typedef logic [ADDR_W-1:0]  wb_addr_t;
	typedef logic [DATA_W-1:0]  wb_data_t;
	typedef logic [SEL_W-1:0]   wb_sel_t;
	typedef logic [STALL_W-1:0] stall_vec_t;  // Bit 0 is PC, bit 5 is write-back

	localparam stall_vec_t STALL_NONE = 6'b000000;
	localparam stall_vec_t STALL_MEM  = 6'b011111;  // PC through memory stage
	localparam stall_vec_t STALL_ALL  = 6'b111111;

	// Bridge FSM states
	typedef enum logic [1:0] {
		WB_IDLE           = 2'b00,
		WB_BUSY           = 2'b01,
		WB_WAIT_FOR_STALL = 2'b11
	} wb_state_t;

endpackage

`default_nettype wire

// ==== hw/wb_bus_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface wb_bus_if
	import wb_pkg::*;
();

	logic     cyc;
	logic     stb;
	wb_addr_t adr;
	wb_data_t dat_w;
	logic     we;
	wb_sel_t  sel;
	wb_data_t dat_r;
	logic     ack;   // One pulse per cycle

	modport master (
		output cyc, stb, adr, dat_w, we, sel,
		input  dat_r, ack
	);

	modport slave (
		input  cyc, stb, adr, dat_w, we, sel,
		output dat_r, ack
	);

endinterface

`default_nettype wire

// ==== hw/mem_req_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface mem_req_if
	import wb_pkg::*;
();

	logic     ce;     // Held until ack with stall clear
	wb_addr_t addr;
	wb_data_t wdata;
	logic     we;
	wb_sel_t  sel;
	wb_data_t rdata;
	logic     ack;

	modport requester (
		output ce, addr, wdata, we, sel,
		input  rdata, ack
	);

	modport bridge (
		input  ce, addr, wdata, we, sel,
		output rdata, ack
	);

endinterface

`default_nettype wire

// ==== hw/wb_master_bridge.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_master_bridge
	import wb_pkg::*;
(
	input  logic       clk,
	input  logic       rst_i,
	input  stall_vec_t stall_i,
	input  logic       flush_i,
	mem_req_if.bridge  req,
	wb_bus_if.master   bus,
	output logic       stall_req_o
);

	wb_state_t state;
	logic      cyc_q;
	logic      stb_q;
	logic      we_q;
	wb_addr_t  adr_q;
	wb_data_t  dat_w_q;
	wb_sel_t   sel_q;
	wb_data_t  rd_buf;
	wb_data_t  rdata;
	logic      start;
	logic      done;
	logic      abort;

	assign start = (state == WB_IDLE) && req.ce && !flush_i;
	assign done  = (state == WB_BUSY) && bus.ack;
	assign abort = (state == WB_BUSY) && !bus.ack && flush_i;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state <= WB_IDLE;
			cyc_q <= 1'b0;
			stb_q <= 1'b0;
			we_q  <= 1'b0;
		end else begin
			case (state)
				WB_IDLE: begin
					if (start) begin
						cyc_q <= 1'b1;
						stb_q <= 1'b1;
						we_q  <= req.we;
						state <= WB_BUSY;
					end
				end
				WB_BUSY: begin
					if (done || abort) begin   // Release the bus
						cyc_q <= 1'b0;
						stb_q <= 1'b0;
						we_q  <= 1'b0;
						state <= WB_IDLE;
					end
					if (done && stall_i != STALL_NONE) begin
						state <= WB_WAIT_FOR_STALL;
					end
				end
				WB_WAIT_FOR_STALL: begin
					if (stall_i == STALL_NONE) begin
						state <= WB_IDLE;
					end
				end
				default: state <= WB_IDLE;
			endcase
		end
	end

	// Request fields and read buffer
	always_ff @(posedge clk) begin
		if (start) begin
			adr_q   <= req.addr;
			dat_w_q <= req.wdata;
			sel_q   <= req.sel;
		end
		if (done) begin
			rd_buf <= we_q ? '0 : bus.dat_r;   // Registered we, not the live request
		end else if (abort) begin
			rd_buf <= '0;
		end
	end

	always_comb begin
		stall_req_o = 1'b0;
		rdata       = '0;
		case (state)
			WB_IDLE: stall_req_o = start;   // Stall from the first cycle of ce
			WB_BUSY: begin
				stall_req_o = !bus.ack;
				if (bus.ack && !we_q) begin
					rdata = bus.dat_r;
				end
			end
			WB_WAIT_FOR_STALL: rdata = rd_buf;   // Replay while held
			default: stall_req_o = 1'b0;
		endcase
	end

	assign req.rdata = rdata;
	assign req.ack   = done;
	assign bus.cyc   = cyc_q;
	assign bus.stb   = stb_q;
	assign bus.we    = we_q;
	assign bus.adr   = adr_q;
	assign bus.dat_w = dat_w_q;
	assign bus.sel   = sel_q;

	a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst_i)
		bus.stb |-> bus.cyc);

	// Bus fields hold for the whole cycle
	a_busy_stable: assert property (@(posedge clk) disable iff (rst_i)
		(state == WB_BUSY && !bus.ack && !flush_i) |=>
		bus.cyc && $stable({bus.adr, bus.dat_w, bus.we, bus.sel}));

endmodule

`default_nettype wire

// ==== hw/pipe_stall_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipe_stall_ctrl
	import wb_pkg::*;
(
	input  logic       mem_stall_req_i,
	input  logic       ext_stall_i,
	input  logic       flush_req_i,
	output stall_vec_t stall_o,
	output logic       flush_o
);

	// Flush wins over both stall sources
	always_comb begin
		flush_o = 1'b0;
		stall_o = STALL_NONE;
		if (flush_req_i) begin
			flush_o = 1'b1;
		end else if (ext_stall_i) begin
			stall_o = STALL_ALL;   // Later stage holds everything
		end else if (mem_stall_req_i) begin
			stall_o = STALL_MEM;   // Write-back keeps draining
		end
	end

endmodule

`default_nettype wire

// ==== hw/wb_sram_slave.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_sram_slave
	import wb_pkg::*;
#(
	parameter int WAIT_STATES = 2,
	parameter int MEM_WORDS   = 256
) (
	input  logic    clk,
	input  logic    rst_i,
	wb_bus_if.slave bus
);

	localparam int IDX_W = $clog2(MEM_WORDS);
	localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;
	localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(WAIT_STATES);

	wb_data_t         mem [MEM_WORDS];
	wb_data_t         dat_q;
	logic [IDX_W-1:0] idx;
	logic [CNT_W-1:0] wait_cnt;
	logic             ack_q;
	logic             fire;

	assign idx  = bus.adr[IDX_W+1:2];   // Word index, wraps modulo MEM_WORDS
	assign fire = bus.cyc && bus.stb && !ack_q && (wait_cnt == WAIT_LAST);

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wait_cnt <= '0;
			ack_q    <= 1'b0;
		end else if (!bus.cyc || !bus.stb || ack_q) begin
			wait_cnt <= '0;   // Idle or just acked
			ack_q    <= 1'b0;
		end else if (fire) begin
			ack_q <= 1'b1;
		end else begin
			wait_cnt <= wait_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			dat_q <= mem[idx];
		end
		// Write commits at the end of the ack cycle so a dropped cyc cancels it
		if (bus.ack && bus.we) begin
			for (int i = 0; i < SEL_W; i++) begin
				if (bus.sel[i]) begin
					mem[idx][8*i +: 8] <= bus.dat_w[8*i +: 8];
				end
			end
		end
	end

	assign bus.dat_r = dat_q;
	assign bus.ack   = ack_q && bus.cyc && bus.stb;   // Pending ack dies with cyc

	// Ack comes a fixed time after the strobe that started it
	a_ack_after_stb: assert property (@(posedge clk) disable iff (rst_i)
		$rose(bus.ack) |-> $past(bus.cyc && bus.stb, WAIT_STATES + 1));

	a_ack_single: assert property (@(posedge clk) disable iff (rst_i)
		bus.ack |=> !bus.ack);

endmodule

`default_nettype wire

// ==== hw/wb_mem_subsys.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_mem_subsys
	import wb_pkg::*;
#(
	parameter int WAIT_STATES = 2,
	parameter int MEM_WORDS   = 256
) (
	input  logic       clk,
	input  logic       rst_i,

	input  logic       req_ce_i,
	input  wb_addr_t   req_addr_i,
	input  wb_data_t   req_wdata_i,
	input  logic       req_we_i,
	input  wb_sel_t    req_sel_i,
	output wb_data_t   req_rdata_o,
	output logic       req_ack_o,

	input  logic       ext_stall_i,
	input  logic       flush_req_i,
	output stall_vec_t stall_o,
	output logic       flush_o
);

	stall_vec_t stall_vec;
	logic       flush;
	logic       mem_stall_req;

	mem_req_if req_bus ();
	wb_bus_if  wb_bus ();

	// Pipeline side of the request
	assign req_bus.ce    = req_ce_i;
	assign req_bus.addr  = req_addr_i;
	assign req_bus.wdata = req_wdata_i;
	assign req_bus.we    = req_we_i;
	assign req_bus.sel   = req_sel_i;
	assign req_rdata_o   = req_bus.rdata;
	assign req_ack_o     = req_bus.ack;

	assign stall_o = stall_vec;
	assign flush_o = flush;

	wb_master_bridge u_bridge (
		.clk         (clk),
		.rst_i       (rst_i),
		.stall_i     (stall_vec),
		.flush_i     (flush),
		.req         (req_bus.bridge),
		.bus         (wb_bus.master),
		.stall_req_o (mem_stall_req)
	);

	pipe_stall_ctrl u_stall_ctrl (
		.mem_stall_req_i (mem_stall_req),
		.ext_stall_i     (ext_stall_i),
		.flush_req_i     (flush_req_i),
		.stall_o         (stall_vec),
		.flush_o         (flush)
	);

	wb_sram_slave #(
		.WAIT_STATES (WAIT_STATES),
		.MEM_WORDS   (MEM_WORDS)
	) u_sram (
		.clk   (clk),
		.rst_i (rst_i),
		.bus   (wb_bus.slave)
	);

endmodule

`default_nettype wire

// ==== tb/tb_wb_mem_subsys.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_wb_mem_subsys
	import wb_pkg::*;
;

	localparam int WAIT_STATES = 2;
	localparam int MEM_WORDS   = 256;
	localparam int ACK_TIMEOUT = 50;
	localparam int NUM_SLOTS   = 8;

	logic       clk;
	logic       rst_i;
	logic       req_ce_i;
	wb_addr_t   req_addr_i;
	wb_data_t   req_wdata_i;
	logic       req_we_i;
	wb_sel_t    req_sel_i;
	wb_data_t   req_rdata_o;
	logic       req_ack_o;
	logic       ext_stall_i;
	logic       flush_req_i;
	stall_vec_t stall_o;
	logic       flush_o;

	wb_data_t   ref_mem [MEM_WORDS];
	int         slot_idx [NUM_SLOTS];
	wb_data_t   exp_rdata;   // Word the pipeline should see at ack
	logic       held;        // Read acked under stall, ce still high
	int         fail_count;
	int         tests_run;
	int         accesses;

	wb_mem_subsys #(
		.WAIT_STATES (WAIT_STATES),
		.MEM_WORDS   (MEM_WORDS)
	) dut_i (
		.clk         (clk),
		.rst_i       (rst_i),
		.req_ce_i    (req_ce_i),
		.req_addr_i  (req_addr_i),
		.req_wdata_i (req_wdata_i),
		.req_we_i    (req_we_i),
		.req_sel_i   (req_sel_i),
		.req_rdata_o (req_rdata_o),
		.req_ack_o   (req_ack_o),
		.ext_stall_i (ext_stall_i),
		.flush_req_i (flush_req_i),
		.stall_o     (stall_o),
		.flush_o     (flush_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
			input logic [31:0] act_val);
		$display("[FAIL] %0t %s expected %h actual %h", $time, sig, exp_val, act_val);
		fail_count++;
	endtask

	task automatic report_error(input string msg);
		$display("[ERROR] %0t %s", $time, msg);
		fail_count++;
	endtask

	a_idle_quiet: assert property (@(posedge clk) disable iff (rst_i)
		(!req_ce_i && !ext_stall_i && !flush_req_i) |->
		(!req_ack_o && stall_o == STALL_NONE && !flush_o))
		else report_error("ack, stall or flush active with no request pending");

	a_ack_latency: assert property (@(posedge clk) disable iff (rst_i || flush_req_i)
		$rose(req_ce_i) |-> !req_ack_o [*WAIT_STATES+2] ##1 req_ack_o)
		else report_error("req_ack_o did not arrive WAIT_STATES+2 cycles after req_ce_i rose");

	a_ack_rdata: assert property (@(posedge clk) disable iff (rst_i)
		req_ack_o |-> req_rdata_o == exp_rdata)
		else report_mismatch("req_rdata_o", $sampled(exp_rdata), $sampled(req_rdata_o));

	a_stall_mem: assert property (@(posedge clk) disable iff (rst_i)
		(req_ce_i && !req_ack_o && !ext_stall_i && !flush_req_i && !held) |->
		stall_o == STALL_MEM)
		else report_mismatch("stall_o", STALL_MEM, $sampled(stall_o));

	a_stall_all: assert property (@(posedge clk) disable iff (rst_i)
		(ext_stall_i && !flush_req_i) |-> stall_o == STALL_ALL)
		else report_mismatch("stall_o", STALL_ALL, $sampled(stall_o));

	a_flush_out: assert property (@(posedge clk) disable iff (rst_i)
		flush_req_i |-> flush_o && stall_o == STALL_NONE)
		else report_mismatch("flush_o/stall_o", {25'd0, 1'b1, STALL_NONE},
			{25'd0, $sampled(flush_o), $sampled(stall_o)});

	// Buffered word replays until the stall is gone
	a_held_rdata: assert property (@(posedge clk) disable iff (rst_i)
		held |-> req_rdata_o == exp_rdata)
		else report_mismatch("req_rdata_o", $sampled(exp_rdata), $sampled(req_rdata_o));

	a_held_no_ack: assert property (@(posedge clk) disable iff (rst_i)
		held |-> !req_ack_o)
		else report_error("second req_ack_o while the read was held by a stall");

	a_flush_no_ack: assert property (@(posedge clk) disable iff (rst_i)
		$fell(flush_req_i) |-> !req_ack_o [*WAIT_STATES+2])
		else report_error("req_ack_o appeared for a flushed access");

	function automatic int word_index(input wb_addr_t addr);
		return int'((addr >> 2) % MEM_WORDS);
	endfunction

	function automatic wb_addr_t random_addr(input int idx);
		wb_addr_t upper;
		upper = $urandom() & ~32'(MEM_WORDS * 4 - 1);   // Random high bits alias the same word
		return upper | wb_addr_t'(idx << 2);
	endfunction

	function automatic void apply_write(input int idx, input wb_data_t data, input wb_sel_t sel);
		for (int i = 0; i < 4; i++) begin
			if (sel[i]) begin
				ref_mem[idx][8*i +: 8] = data[8*i +: 8];
			end
		end
	endfunction

	task automatic stop_on_timeout(input string what);
		$display("Timeout: no req_ack_o within %0d cycles during %s", ACK_TIMEOUT, what);
		$display("TEST FAIL");
		$finish;
	endtask

	task automatic wait_for_ack();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!req_ack_o && waited < ACK_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
	endtask

	task automatic mem_access(input logic we, input wb_addr_t addr, input wb_data_t wdata,
			input wb_sel_t sel);
		int idx;
		idx = word_index(addr);
		@(posedge clk);
		exp_rdata   <= we ? '0 : ref_mem[idx];   // Writes return zero
		req_ce_i    <= 1'b1;
		req_we_i    <= we;
		req_addr_i  <= addr;
		req_wdata_i <= wdata;
		req_sel_i   <= sel;
		wait_for_ack();
		if (!req_ack_o) begin
			stop_on_timeout(we ? "write" : "read");
		end else begin
			if (we) begin
				apply_write(idx, wdata, sel);
			end
			accesses++;
			@(posedge clk);
			req_ce_i <= 1'b0;
			req_we_i <= 1'b0;
		end
	endtask

	task automatic read_under_stall(input wb_addr_t addr, input int hold_cycles);
		int idx;
		idx = word_index(addr);
		@(posedge clk);
		exp_rdata   <= ref_mem[idx];
		ext_stall_i <= 1'b1;
		req_ce_i    <= 1'b1;
		req_we_i    <= 1'b0;
		req_addr_i  <= addr;
		req_sel_i   <= 4'hf;
		wait_for_ack();
		if (!req_ack_o) begin
			stop_on_timeout("stalled read");
		end else begin
			accesses++;
			@(posedge clk);
			held <= 1'b1;
			repeat (hold_cycles) @(posedge clk);
			ext_stall_i <= 1'b0;
			@(posedge clk);   // Stall seen clear, request retires
			req_ce_i <= 1'b0;
			held     <= 1'b0;
		end
	endtask

	task automatic write_then_flush(input wb_addr_t addr, input wb_data_t wdata);
		@(posedge clk);
		exp_rdata   <= '0;
		req_ce_i    <= 1'b1;
		req_we_i    <= 1'b1;
		req_addr_i  <= addr;
		req_wdata_i <= wdata;
		req_sel_i   <= 4'hf;
		@(posedge clk);
		flush_req_i <= 1'b1;   // Bridge is busy, slave not yet acked
		@(posedge clk);
		flush_req_i <= 1'b0;
		req_ce_i    <= 1'b0;
		req_we_i    <= 1'b0;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		$display("Test %0d %s finished, failures so far %0d", tests_run, name, fail_count);
	endtask

	initial begin
		int idx;
		void'($urandom(32'he1fd));
		rst_i       = 1'b1;
		req_ce_i    = 1'b0;
		req_addr_i  = '0;
		req_wdata_i = '0;
		req_we_i    = 1'b0;
		req_sel_i   = '0;
		ext_stall_i = 1'b0;
		flush_req_i = 1'b0;
		exp_rdata   = '0;
		held        = 1'b0;
		fail_count  = 0;
		tests_run   = 0;
		accesses    = 0;
		repeat (2) @(posedge clk);
		rst_i <= 1'b0;

		repeat (4) @(posedge clk);
		end_test("reset_state");

		for (int i = 0; i < NUM_SLOTS; i++) begin
			slot_idx[i] = $urandom_range(MEM_WORDS - 1);
			mem_access(1'b1, random_addr(slot_idx[i]), $urandom(), 4'hf);
		end
		for (int i = 0; i < NUM_SLOTS; i++) begin
			mem_access(1'b0, random_addr(slot_idx[i]), '0, 4'hf);
		end
		end_test("write_read_back");

		for (int i = 0; i < 2 * NUM_SLOTS; i++) begin
			idx = slot_idx[$urandom_range(NUM_SLOTS - 1)];
			mem_access(1'b1, random_addr(idx), $urandom(), wb_sel_t'($urandom_range(14, 1)));
			mem_access(1'b0, random_addr(idx), '0, 4'hf);
		end
		end_test("byte_lane_writes");

		@(posedge clk);
		ext_stall_i <= 1'b1;
		repeat (3) @(posedge clk);
		ext_stall_i <= 1'b0;
		flush_req_i <= 1'b1;
		repeat (2) @(posedge clk);
		flush_req_i <= 1'b0;
		mem_access(1'b0, random_addr(slot_idx[1]), '0, 4'hf);   // STALL_MEM while outstanding
		end_test("stall_vector");

		for (int i = 0; i < 3; i++) begin
			read_under_stall(random_addr(slot_idx[i]), 2 + i);
		end
		mem_access(1'b0, random_addr(slot_idx[3]), '0, 4'hf);
		end_test("back_pressure");

		idx = slot_idx[0];
		write_then_flush(random_addr(idx), ~ref_mem[idx]);
		mem_access(1'b0, random_addr(idx), '0, 4'hf);   // Memory must be unchanged
		end_test("flush");

		repeat (4) @(posedge clk);
		$display("Summary: %0d tests, %0d accesses, %0d failures", tests_run, accesses,
			fail_count);
		if (fail_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
hw/wb_pkg.sv
hw/wb_bus_if.sv
hw/mem_req_if.sv
hw/wb_master_bridge.sv
hw/pipe_stall_ctrl.sv
hw/wb_sram_slave.sv
hw/wb_mem_subsys.sv
tb/tb_wb_mem_subsys.sv
